// File: rw_mgr_pkg.sv
/* rw manager shared definitions */

package rw_mgr_pkg;

	localparam int AFI_RATIO       = 2;
	localparam int NUM_BEATS       = 2 * AFI_RATIO;
	localparam int MEM_DQ_WIDTH    = 16;
	localparam int MEM_DM_WIDTH    = 2;
	localparam int DQ_PER_GROUP    = 8;
	localparam int NUM_RANKS       = 2;
	localparam int AC_BUS_WIDTH    = 16;
	localparam int AC_WORD_WIDTH   = AC_BUS_WIDTH + AFI_RATIO;
	localparam int INST_ADDR_WIDTH = 7;
	localparam int AC_ADDR_WIDTH   = 6;
	localparam int CNTR_WIDTH      = 8;
	localparam int APB_ADDR_WIDTH  = 12;
	localparam int APB_DATA_WIDTH  = 32;
	localparam int EXP_DEPTH       = 4;

	// afi side bus widths
	localparam int WDATA_WIDTH = MEM_DQ_WIDTH * NUM_BEATS;
	localparam int WDM_WIDTH   = MEM_DM_WIDTH * NUM_BEATS;
	localparam int CS_WIDTH    = AFI_RATIO * NUM_RANKS;

	// instruction word layout, top bit down
	localparam int JUMP_REG_WIDTH = 2;
	localparam int NUM_LOOPS      = 2 ** JUMP_REG_WIDTH;
	localparam int DO_CODE_WIDTH  = 4;
	localparam int DM_CODE_WIDTH  = 3;
	localparam int INST_WIDTH     = 18;
	localparam int INST_RETURN_BIT = 17;
	localparam int INST_R_WN_BIT   = 16;
	localparam int INST_JUMP_BIT   = 15;
	localparam int INST_JREG_LSB   = 13;
	localparam int INST_AC_LSB     = 7;
	localparam int INST_DO_LSB     = 3;
	localparam int INST_DM_LSB     = 0;

	typedef logic [INST_WIDTH-1:0] inst_t;

	// bits 17:16 are the chip selects of afi words 1 and 0
	typedef logic [AC_WORD_WIDTH-1:0] ac_word_t;

	typedef enum logic [3:0] {
		OP_RUN         = 4'd0,
		OP_LOAD_CNTR   = 4'd2,
		OP_LOAD_JUMP   = 4'd3,
		OP_CLEAR_ERR   = 4'd4,
		OP_SET_CS_MASK = 4'd5,
		OP_WRITE_INST  = 4'd6,
		OP_WRITE_AC    = 4'd7
	} cmd_op_t;

	// each set bit of the code drives one whole beat high
	function automatic logic [WDATA_WIDTH-1:0] expand_do(input logic [DO_CODE_WIDTH-1:0] code);
		logic [WDATA_WIDTH-1:0] data;
		for (int w = 0; w < NUM_BEATS; w++) begin
			data[w*MEM_DQ_WIDTH +: MEM_DQ_WIDTH] = {MEM_DQ_WIDTH{code[w]}};
		end
		return data;
	endfunction

endpackage

// File: rw_mgr_ram.sv
/* microcode and ac word memory */

module rw_mgr_ram #(
	parameter type T  = logic [17:0],
	parameter int  AW = 6
) (
	input  logic          afi_clk_i,
	input  logic          wr_en_i,
	input  logic [AW-1:0] wr_addr_i,
	input  T              wr_data_i,
	input  logic [AW-1:0] rd_addr_i,
	output T              rd_data_o
);

	T mem [2**AW];

	always_ff @(posedge afi_clk_i) begin
		if (wr_en_i) begin
			mem[wr_addr_i] <= wr_data_i;
		end
		rd_data_o <= mem[rd_addr_i];
	end

	// the host must never write through an unknown address
	assert property (@(posedge afi_clk_i) wr_en_i |-> !$isunknown(wr_addr_i));

endmodule

// File: rw_mgr_jump_logic.sv
/* loop counters and jump targets */

module rw_mgr_jump_logic (
	input  logic                                       afi_clk_i,
	input  logic                                       afi_reset_n_i,
	input  logic                                       load_cntr_i,
	input  logic                                       load_jump_i,
	input  logic [rw_mgr_pkg::JUMP_REG_WIDTH-1:0]      load_sel_i,
	input  logic [rw_mgr_pkg::CNTR_WIDTH-1:0]          load_value_i,
	input  logic                                       jump_i,
	input  logic [rw_mgr_pkg::JUMP_REG_WIDTH-1:0]      jump_reg_i,
	output logic                                       jump_taken_o,
	output logic [rw_mgr_pkg::INST_ADDR_WIDTH-1:0]     jump_addr_o
);

	logic [rw_mgr_pkg::CNTR_WIDTH-1:0]      cntr  [rw_mgr_pkg::NUM_LOOPS];
	logic [rw_mgr_pkg::INST_ADDR_WIDTH-1:0] jaddr [rw_mgr_pkg::NUM_LOOPS];

	// a zero counter falls through, so the body runs count plus one times
	assign jump_taken_o = jump_i && (cntr[jump_reg_i] != '0);
	assign jump_addr_o  = jaddr[jump_reg_i];

	always_ff @(posedge afi_clk_i or negedge afi_reset_n_i) begin
		if (!afi_reset_n_i) begin
			for (int i = 0; i < rw_mgr_pkg::NUM_LOOPS; i++) begin
				cntr[i]  <= '0;
				jaddr[i] <= '0;
			end
		end else begin
			if (load_cntr_i) begin
				cntr[load_sel_i] <= load_value_i;
			end else if (jump_taken_o) begin
				cntr[jump_reg_i] <= cntr[jump_reg_i] - 1'b1;
			end
			if (load_jump_i) begin
				jaddr[load_sel_i] <= load_value_i[rw_mgr_pkg::INST_ADDR_WIDTH-1:0];
			end
		end
	end

endmodule

// File: rw_mgr_sequencer.sv
/* program counter and instruction decode */

module rw_mgr_sequencer (
	input  logic                                   afi_clk_i,
	input  logic                                   afi_reset_n_i,
	input  logic                                   start_i,
	input  logic [rw_mgr_pkg::INST_ADDR_WIDTH-1:0] start_addr_i,
	input  rw_mgr_pkg::inst_t                      inst_i,
	input  logic                                   jump_taken_i,
	input  logic [rw_mgr_pkg::INST_ADDR_WIDTH-1:0] jump_addr_i,
	input  logic                                   running_i,
	output logic [rw_mgr_pkg::INST_ADDR_WIDTH-1:0] next_pc_o,
	output logic [rw_mgr_pkg::INST_ADDR_WIDTH-1:0] pc_o,
	output logic                                   return_o,
	output logic                                   r_wn_o,
	output logic                                   jump_o,
	output logic [rw_mgr_pkg::JUMP_REG_WIDTH-1:0]  jump_reg_o,
	output logic [rw_mgr_pkg::AC_ADDR_WIDTH-1:0]   ac_addr_o,
	output logic [rw_mgr_pkg::DO_CODE_WIDTH-1:0]   do_code_o,
	output logic [rw_mgr_pkg::DM_CODE_WIDTH-1:0]   dm_code_o
);

	// the ram word is unknown until loaded, so the control bits only count while running
	assign return_o   = running_i && inst_i[rw_mgr_pkg::INST_RETURN_BIT];
	assign r_wn_o     = running_i && inst_i[rw_mgr_pkg::INST_R_WN_BIT];
	assign jump_o     = running_i && inst_i[rw_mgr_pkg::INST_JUMP_BIT];
	assign jump_reg_o = inst_i[rw_mgr_pkg::INST_JREG_LSB +: rw_mgr_pkg::JUMP_REG_WIDTH];
	assign ac_addr_o  = inst_i[rw_mgr_pkg::INST_AC_LSB +: rw_mgr_pkg::AC_ADDR_WIDTH];

	// idle keeps the data pins at zero
	assign do_code_o = running_i ?
		inst_i[rw_mgr_pkg::INST_DO_LSB +: rw_mgr_pkg::DO_CODE_WIDTH] : '0;
	assign dm_code_o = running_i ?
		inst_i[rw_mgr_pkg::INST_DM_LSB +: rw_mgr_pkg::DM_CODE_WIDTH] : '0;

	always_comb begin
		if (start_i) begin
			next_pc_o = start_addr_i;
		end else if (jump_taken_i) begin
			next_pc_o = jump_addr_i;
		end else if (return_o || !running_i) begin
			next_pc_o = pc_o;
		end else begin
			next_pc_o = pc_o + 1'b1;
		end
	end

	always_ff @(posedge afi_clk_i or negedge afi_reset_n_i) begin
		if (!afi_reset_n_i) begin
			pc_o <= '0;
		end else begin
			pc_o <= next_pc_o;
		end
	end

	// the host only starts a program from idle
	assert property (@(posedge afi_clk_i) disable iff (!afi_reset_n_i)
		!(start_i && running_i));

endmodule

// File: rw_mgr_write_pattern.sv
/* afi write data generator */

module rw_mgr_write_pattern (
	input  logic                                 afi_clk_i,
	input  logic                                 afi_reset_n_i,
	input  logic [rw_mgr_pkg::DO_CODE_WIDTH-1:0] do_code_i,
	input  logic [rw_mgr_pkg::DM_CODE_WIDTH-1:0] dm_code_i,
	output logic [rw_mgr_pkg::WDATA_WIDTH-1:0]   afi_wdata_o,
	output logic [rw_mgr_pkg::WDM_WIDTH-1:0]     afi_dm_o
);

	always_ff @(posedge afi_clk_i or negedge afi_reset_n_i) begin
		if (!afi_reset_n_i) begin
			afi_wdata_o <= '0;
			afi_dm_o    <= '0;
		end else begin
			afi_wdata_o <= rw_mgr_pkg::expand_do(do_code_i);
			// the dm code counts how many leading beats are masked
			for (int w = 0; w < rw_mgr_pkg::NUM_BEATS; w++) begin
				afi_dm_o[w*rw_mgr_pkg::MEM_DM_WIDTH +: rw_mgr_pkg::MEM_DM_WIDTH] <=
					{rw_mgr_pkg::MEM_DM_WIDTH{w < dm_code_i}};
			end
		end
	end

endmodule

// File: rw_mgr_read_checker.sv
/* read data compare and error word */

module rw_mgr_read_checker (
	input  logic                                 afi_clk_i,
	input  logic                                 afi_reset_n_i,
	input  logic                                 push_i,
	input  logic [rw_mgr_pkg::DO_CODE_WIDTH-1:0] do_code_i,
	input  logic                                 clear_i,
	input  logic [rw_mgr_pkg::WDATA_WIDTH-1:0]   afi_rdata_i,
	input  logic                                 afi_rdata_valid_i,
	output logic [rw_mgr_pkg::DQ_PER_GROUP-1:0]  error_word_o
);

	logic [rw_mgr_pkg::DO_CODE_WIDTH-1:0]       exp_q [rw_mgr_pkg::EXP_DEPTH];
	logic [$clog2(rw_mgr_pkg::EXP_DEPTH)-1:0]   wr_ptr;
	logic [$clog2(rw_mgr_pkg::EXP_DEPTH)-1:0]   rd_ptr;
	logic [$clog2(rw_mgr_pkg::EXP_DEPTH+1)-1:0] count;
	logic [rw_mgr_pkg::WDATA_WIDTH-1:0]         mismatch;
	logic [rw_mgr_pkg::DQ_PER_GROUP-1:0]        err_now;

	// fold every group of every beat onto one dq position
	always_comb begin
		mismatch = afi_rdata_i ^ rw_mgr_pkg::expand_do(exp_q[rd_ptr]);
		err_now  = '0;
		for (int s = 0; s < rw_mgr_pkg::WDATA_WIDTH / rw_mgr_pkg::DQ_PER_GROUP; s++) begin
			err_now |= mismatch[s*rw_mgr_pkg::DQ_PER_GROUP +: rw_mgr_pkg::DQ_PER_GROUP];
		end
	end

	always_ff @(posedge afi_clk_i) begin
		if (push_i) begin
			exp_q[wr_ptr] <= do_code_i;
		end
	end

	always_ff @(posedge afi_clk_i or negedge afi_reset_n_i) begin
		if (!afi_reset_n_i) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			count        <= '0;
			error_word_o <= '0;
		end else if (clear_i) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			count        <= '0;
			error_word_o <= '0;
		end else begin
			if (push_i) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (afi_rdata_valid_i) begin
				rd_ptr       <= rd_ptr + 1'b1;
				error_word_o <= error_word_o | err_now;
			end
			case ({push_i, afi_rdata_valid_i})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	// no more than EXP_DEPTH reads may be in flight
	assert property (@(posedge afi_clk_i) disable iff (!afi_reset_n_i)
		!(push_i && !afi_rdata_valid_i && count == rw_mgr_pkg::EXP_DEPTH));
	assert property (@(posedge afi_clk_i) disable iff (!afi_reset_n_i)
		!(afi_rdata_valid_i && count == '0));

endmodule

// File: rw_mgr_apb_ctrl.sv
/* apb command decode and run control */

module rw_mgr_apb_ctrl (
	input  logic                                   afi_clk_i,
	input  logic                                   afi_reset_n_i,
	input  logic                                   psel_i,
	input  logic                                   penable_i,
	input  logic                                   pwrite_i,
	input  logic [rw_mgr_pkg::APB_ADDR_WIDTH-1:0]  paddr_i,
	input  logic [rw_mgr_pkg::APB_DATA_WIDTH-1:0]  pwdata_i,
	output logic [rw_mgr_pkg::APB_DATA_WIDTH-1:0]  prdata_o,
	output logic                                   pready_o,
	input  logic                                   return_i,
	input  logic [rw_mgr_pkg::INST_ADDR_WIDTH-1:0] pc_i,
	input  logic [rw_mgr_pkg::DQ_PER_GROUP-1:0]    error_word_i,
	output logic                                   start_o,
	output logic [rw_mgr_pkg::INST_ADDR_WIDTH-1:0] start_addr_o,
	output logic                                   running_o,
	output logic                                   inst_wr_o,
	output logic                                   ac_wr_o,
	output logic [rw_mgr_pkg::INST_ADDR_WIDTH-1:0] wr_addr_o,
	output logic [rw_mgr_pkg::APB_DATA_WIDTH-1:0]  wr_data_o,
	output logic                                   load_cntr_o,
	output logic                                   load_jump_o,
	output logic [rw_mgr_pkg::JUMP_REG_WIDTH-1:0]  load_sel_o,
	output logic [rw_mgr_pkg::CNTR_WIDTH-1:0]      load_value_o,
	output logic                                   clear_err_o,
	output logic [rw_mgr_pkg::NUM_RANKS-1:0]       cs_mask_o
);

	typedef enum logic [1:0] {ST_IDLE, ST_RUNNING, ST_DONE} state_t;

	state_t              state;
	rw_mgr_pkg::cmd_op_t op;
	logic                accept;
	logic                set_mask;

	assign op     = rw_mgr_pkg::cmd_op_t'(paddr_i[rw_mgr_pkg::APB_ADDR_WIDTH-1 -: 4]);
	assign accept = psel_i && penable_i && (state == ST_IDLE);

	// a run holds pready low until its return instruction has executed
	assign pready_o = (accept && !(pwrite_i && op == rw_mgr_pkg::OP_RUN)) ||
		(psel_i && penable_i && state == ST_DONE);
	assign running_o = (state == ST_RUNNING);

	assign start_addr_o = pwdata_i[rw_mgr_pkg::INST_ADDR_WIDTH-1:0];
	assign wr_addr_o    = paddr_i[rw_mgr_pkg::INST_ADDR_WIDTH-1:0];
	assign wr_data_o    = pwdata_i;
	assign load_sel_o   = paddr_i[rw_mgr_pkg::JUMP_REG_WIDTH-1:0];
	assign load_value_o = pwdata_i[rw_mgr_pkg::CNTR_WIDTH-1:0];

	always_comb begin
		start_o     = 1'b0;
		load_cntr_o = 1'b0;
		load_jump_o = 1'b0;
		clear_err_o = 1'b0;
		set_mask    = 1'b0;
		inst_wr_o   = 1'b0;
		ac_wr_o     = 1'b0;
		if (accept && pwrite_i) begin
			case (op)
				rw_mgr_pkg::OP_RUN:         start_o     = 1'b1;
				rw_mgr_pkg::OP_LOAD_CNTR:   load_cntr_o = 1'b1;
				rw_mgr_pkg::OP_LOAD_JUMP:   load_jump_o = 1'b1;
				rw_mgr_pkg::OP_CLEAR_ERR:   clear_err_o = 1'b1;
				rw_mgr_pkg::OP_SET_CS_MASK: set_mask    = 1'b1;
				rw_mgr_pkg::OP_WRITE_INST:  inst_wr_o   = 1'b1;
				rw_mgr_pkg::OP_WRITE_AC:    ac_wr_o     = 1'b1;
				default: ;
			endcase
		end
	end

	always_comb begin
		prdata_o = '0;
		if (paddr_i[0]) begin
			prdata_o[rw_mgr_pkg::INST_ADDR_WIDTH-1:0] = pc_i;
		end else begin
			prdata_o[rw_mgr_pkg::DQ_PER_GROUP-1:0] = error_word_i;
		end
	end

	always_ff @(posedge afi_clk_i or negedge afi_reset_n_i) begin
		if (!afi_reset_n_i) begin
			state     <= ST_IDLE;
			cs_mask_o <= '0;
		end else begin
			if (set_mask) begin
				cs_mask_o <= pwdata_i[rw_mgr_pkg::NUM_RANKS-1:0];
			end
			case (state)
				ST_IDLE: begin
					if (start_o) begin
						state <= ST_RUNNING;
					end
				end
				ST_RUNNING: begin
					if (return_i) begin
						state <= ST_DONE;
					end
				end
				default: begin
					// stay done until the host closes the access cycle
					if (!(psel_i && penable_i)) begin
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	assert property (@(posedge afi_clk_i) disable iff (!afi_reset_n_i)
		(psel_i && penable_i && !pready_o) |=> $stable(paddr_i));

endmodule

// File: rw_mgr_core.sv
/* rw manager top level */

module rw_mgr_core (
	input  logic                                  afi_clk_i,
	input  logic                                  afi_reset_n_i,
	input  logic                                  psel_i,
	input  logic                                  penable_i,
	input  logic                                  pwrite_i,
	input  logic [rw_mgr_pkg::APB_ADDR_WIDTH-1:0] paddr_i,
	input  logic [rw_mgr_pkg::APB_DATA_WIDTH-1:0] pwdata_i,
	output logic [rw_mgr_pkg::APB_DATA_WIDTH-1:0] prdata_o,
	output logic                                  pready_o,
	output logic [rw_mgr_pkg::AC_BUS_WIDTH-1:0]   ac_bus_o,
	output logic [rw_mgr_pkg::CS_WIDTH-1:0]       ac_cs_n_o,
	output logic [rw_mgr_pkg::WDATA_WIDTH-1:0]    afi_wdata_o,
	output logic [rw_mgr_pkg::WDM_WIDTH-1:0]      afi_dm_o,
	input  logic [rw_mgr_pkg::WDATA_WIDTH-1:0]    afi_rdata_i,
	input  logic                                  afi_rdata_valid_i
);

	rw_mgr_pkg::inst_t                      inst;
	rw_mgr_pkg::ac_word_t                   ac_word;
	logic [rw_mgr_pkg::INST_ADDR_WIDTH-1:0] next_pc, pc, start_addr, jump_addr, wr_addr;
	logic [rw_mgr_pkg::APB_DATA_WIDTH-1:0]  wr_data;
	logic [rw_mgr_pkg::JUMP_REG_WIDTH-1:0]  jump_reg, load_sel;
	logic [rw_mgr_pkg::CNTR_WIDTH-1:0]      load_value;
	logic [rw_mgr_pkg::AC_ADDR_WIDTH-1:0]   ac_addr;
	logic [rw_mgr_pkg::DO_CODE_WIDTH-1:0]   do_code;
	logic [rw_mgr_pkg::DM_CODE_WIDTH-1:0]   dm_code;
	logic [rw_mgr_pkg::DQ_PER_GROUP-1:0]    error_word;
	logic [rw_mgr_pkg::NUM_RANKS-1:0]       cs_mask;
	logic start, running, ret, r_wn, jump, jump_taken;
	logic inst_wr, ac_wr, load_cntr, load_jump, clear_err;

	assign ac_bus_o = ac_word[rw_mgr_pkg::AC_BUS_WIDTH-1:0];

	// one chip select per rank in each afi word, forced high by the mask
	for (genvar w = 0; w < rw_mgr_pkg::AFI_RATIO; w++) begin : g_word
		for (genvar r = 0; r < rw_mgr_pkg::NUM_RANKS; r++) begin : g_rank
			assign ac_cs_n_o[w*rw_mgr_pkg::NUM_RANKS + r] =
				ac_word[rw_mgr_pkg::AC_BUS_WIDTH + w] | cs_mask[r];
		end
	end

	rw_mgr_apb_ctrl apb_ctrl_i (
		.afi_clk_i, .afi_reset_n_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
		.prdata_o, .pready_o,
		.return_i(ret), .pc_i(pc), .error_word_i(error_word),
		.start_o(start), .start_addr_o(start_addr), .running_o(running),
		.inst_wr_o(inst_wr), .ac_wr_o(ac_wr), .wr_addr_o(wr_addr), .wr_data_o(wr_data),
		.load_cntr_o(load_cntr), .load_jump_o(load_jump), .load_sel_o(load_sel),
		.load_value_o(load_value), .clear_err_o(clear_err), .cs_mask_o(cs_mask)
	);

	rw_mgr_sequencer sequencer_i (
		.afi_clk_i, .afi_reset_n_i,
		.start_i(start), .start_addr_i(start_addr), .inst_i(inst),
		.jump_taken_i(jump_taken), .jump_addr_i(jump_addr), .running_i(running),
		.next_pc_o(next_pc), .pc_o(pc), .return_o(ret), .r_wn_o(r_wn), .jump_o(jump),
		.jump_reg_o(jump_reg), .ac_addr_o(ac_addr), .do_code_o(do_code), .dm_code_o(dm_code)
	);

	rw_mgr_jump_logic jump_logic_i (
		.afi_clk_i, .afi_reset_n_i,
		.load_cntr_i(load_cntr), .load_jump_i(load_jump), .load_sel_i(load_sel),
		.load_value_i(load_value), .jump_i(jump), .jump_reg_i(jump_reg),
		.jump_taken_o(jump_taken), .jump_addr_o(jump_addr)
	);

	rw_mgr_ram #(.T(rw_mgr_pkg::inst_t), .AW(rw_mgr_pkg::INST_ADDR_WIDTH)) inst_ram_i (
		.afi_clk_i, .wr_en_i(inst_wr), .wr_addr_i(wr_addr),
		.wr_data_i(wr_data[rw_mgr_pkg::INST_WIDTH-1:0]),
		.rd_addr_i(next_pc), .rd_data_o(inst)
	);

	rw_mgr_ram #(.T(rw_mgr_pkg::ac_word_t), .AW(rw_mgr_pkg::AC_ADDR_WIDTH)) ac_ram_i (
		.afi_clk_i, .wr_en_i(ac_wr), .wr_addr_i(wr_addr[rw_mgr_pkg::AC_ADDR_WIDTH-1:0]),
		.wr_data_i(wr_data[rw_mgr_pkg::AC_WORD_WIDTH-1:0]),
		.rd_addr_i(ac_addr), .rd_data_o(ac_word)
	);

	rw_mgr_write_pattern write_pattern_i (
		.afi_clk_i, .afi_reset_n_i, .do_code_i(do_code), .dm_code_i(dm_code),
		.afi_wdata_o, .afi_dm_o
	);

	rw_mgr_read_checker read_checker_i (
		.afi_clk_i, .afi_reset_n_i, .push_i(r_wn), .do_code_i(do_code), .clear_i(clear_err),
		.afi_rdata_i, .afi_rdata_valid_i, .error_word_o(error_word)
	);

endmodule

// File: tb_rw_mgr_core.sv
/* rw manager testbench */

module tb_rw_mgr_core;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 20;

	logic                                  afi_clk;
	logic                                  afi_reset_n;
	logic                                  psel;
	logic                                  penable;
	logic                                  pwrite;
	logic [rw_mgr_pkg::APB_ADDR_WIDTH-1:0] paddr;
	logic [rw_mgr_pkg::APB_DATA_WIDTH-1:0] pwdata;
	logic [rw_mgr_pkg::APB_DATA_WIDTH-1:0] prdata;
	logic                                  pready;
	logic [rw_mgr_pkg::AC_BUS_WIDTH-1:0]   ac_bus;
	logic [rw_mgr_pkg::CS_WIDTH-1:0]       ac_cs_n;
	logic [rw_mgr_pkg::WDATA_WIDTH-1:0]    afi_wdata;
	logic [rw_mgr_pkg::WDM_WIDTH-1:0]      afi_dm;
	logic [rw_mgr_pkg::WDATA_WIDTH-1:0]    afi_rdata;
	logic                                  afi_rdata_valid;

	// host side copies of everything loaded into the DUT
	rw_mgr_pkg::inst_t                   inst_mem [2**rw_mgr_pkg::INST_ADDR_WIDTH];
	rw_mgr_pkg::ac_word_t                ac_mem [2**rw_mgr_pkg::AC_ADDR_WIDTH];
	int                                  cntr_model [rw_mgr_pkg::NUM_LOOPS];
	int                                  jaddr_model [rw_mgr_pkg::NUM_LOOPS];
	logic [rw_mgr_pkg::NUM_RANKS-1:0]    cur_mask;
	logic [rw_mgr_pkg::DQ_PER_GROUP-1:0] exp_err;

	int                                  trace_q [$];
	int                                  rsp_due [$];
	logic [rw_mgr_pkg::WDATA_WIDTH-1:0]  rsp_data [$];
	logic                                flip_on;
	logic                                run_go;
	int                                  cyc = 0;
	int                                  budget = 40;
	int                                  errors = 0;
	int                                  checks = 0;
	int                                  tests = 0;
	integer                              seed = 32'h8c3d6dda;

	rw_mgr_core rw_mgr_core_i (
		.afi_clk_i(afi_clk), .afi_reset_n_i(afi_reset_n),
		.psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
		.pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
		.ac_bus_o(ac_bus), .ac_cs_n_o(ac_cs_n), .afi_wdata_o(afi_wdata), .afi_dm_o(afi_dm),
		.afi_rdata_i(afi_rdata), .afi_rdata_valid_i(afi_rdata_valid)
	);

	initial begin
		afi_clk = 1'b0;
		forever #(CLK_PERIOD / 2) afi_clk = ~afi_clk;
	end

	always @(posedge afi_clk) begin
		cyc <= cyc + 1;
	end

	function automatic logic [rw_mgr_pkg::WDATA_WIDTH-1:0] wdata_ref(input logic [3:0] code);
		logic [rw_mgr_pkg::WDATA_WIDTH-1:0] d;
		for (int w = 0; w < rw_mgr_pkg::NUM_BEATS; w++) begin
			for (int b = 0; b < rw_mgr_pkg::MEM_DQ_WIDTH; b++) begin
				d[w*rw_mgr_pkg::MEM_DQ_WIDTH + b] = code[w];
			end
		end
		return d;
	endfunction

	function automatic logic [rw_mgr_pkg::WDM_WIDTH-1:0] dm_ref(input logic [2:0] code);
		logic [rw_mgr_pkg::WDM_WIDTH-1:0] m;
		for (int w = 0; w < rw_mgr_pkg::NUM_BEATS; w++) begin
			for (int b = 0; b < rw_mgr_pkg::MEM_DM_WIDTH; b++) begin
				m[w*rw_mgr_pkg::MEM_DM_WIDTH + b] = (w < code);
			end
		end
		return m;
	endfunction

	function automatic logic [rw_mgr_pkg::CS_WIDTH-1:0] cs_ref(input rw_mgr_pkg::ac_word_t ac,
		input logic [rw_mgr_pkg::NUM_RANKS-1:0] mask);
		logic [rw_mgr_pkg::CS_WIDTH-1:0] c;
		for (int w = 0; w < rw_mgr_pkg::AFI_RATIO; w++) begin
			for (int r = 0; r < rw_mgr_pkg::NUM_RANKS; r++) begin
				c[w*rw_mgr_pkg::NUM_RANKS + r] = ac[rw_mgr_pkg::AC_BUS_WIDTH + w] | mask[r];
			end
		end
		return c;
	endfunction

	// a flip anywhere marks its dq position within the group
	function automatic logic [7:0] err_ref(input logic [rw_mgr_pkg::WDATA_WIDTH-1:0] flips);
		logic [7:0] e;
		e = '0;
		for (int b = 0; b < rw_mgr_pkg::WDATA_WIDTH; b++) begin
			if (flips[b]) begin
				e[b % rw_mgr_pkg::DQ_PER_GROUP] = 1'b1;
			end
		end
		return e;
	endfunction

	function automatic rw_mgr_pkg::inst_t make_inst(input logic ret, rwn, jmp,
		input int jreg, ac, dout, dm);
		rw_mgr_pkg::inst_t i;
		i = '0;
		i[rw_mgr_pkg::INST_RETURN_BIT] = ret;
		i[rw_mgr_pkg::INST_R_WN_BIT]   = rwn;
		i[rw_mgr_pkg::INST_JUMP_BIT]   = jmp;
		i[rw_mgr_pkg::INST_JREG_LSB +: 2] = jreg[1:0];
		i[rw_mgr_pkg::INST_AC_LSB +: rw_mgr_pkg::AC_ADDR_WIDTH] = ac[5:0];
		i[rw_mgr_pkg::INST_DO_LSB +: rw_mgr_pkg::DO_CODE_WIDTH] = dout[3:0];
		i[rw_mgr_pkg::INST_DM_LSB +: rw_mgr_pkg::DM_CODE_WIDTH] = dm[2:0];
		return i;
	endfunction

	// walks the program the way the loop rules say and lists the executed addresses
	function automatic void build_trace(input int start);
		int pc;
		int jreg;
		rw_mgr_pkg::inst_t inst;
		pc = start;
		for (int n = 0; n < 256; n++) begin
			inst = inst_mem[pc];
			trace_q.push_back(pc);
			if (inst[rw_mgr_pkg::INST_RETURN_BIT]) begin
				break;
			end
			jreg = inst[rw_mgr_pkg::INST_JREG_LSB +: 2];
			if (inst[rw_mgr_pkg::INST_JUMP_BIT] && cntr_model[jreg] != 0) begin
				cntr_model[jreg]--;
				pc = jaddr_model[jreg];
			end else begin
				pc = pc + 1;
			end
		end
	endfunction

	task automatic ac_cmp(input logic [rw_mgr_pkg::AC_BUS_WIDTH-1:0] got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch ac_bus_o at %0t: got %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic cs_cmp(input logic [rw_mgr_pkg::CS_WIDTH-1:0] got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch ac_cs_n_o at %0t: got %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic wdata_cmp(input logic [rw_mgr_pkg::WDATA_WIDTH-1:0] got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch afi_wdata_o at %0t: got %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic dm_cmp(input logic [rw_mgr_pkg::WDM_WIDTH-1:0] got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch afi_dm_o at %0t: got %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic reg_cmp(input string name, input logic [rw_mgr_pkg::APB_DATA_WIDTH-1:0] got,
		input logic [rw_mgr_pkg::APB_DATA_WIDTH-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch prdata_o (%s): got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata);
		int waits;
		logic is_run;
		budget += 6;
		is_run = wr && (addr[11:8] == rw_mgr_pkg::OP_RUN);
		@(negedge afi_clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge afi_clk);
		penable = 1'b1;
		if (is_run) begin
			run_go = 1'b1;
		end
		#1;
		waits = 0;
		while (pready !== 1'b1) begin
			@(negedge afi_clk);
			#1;
			waits++;
		end
		rdata = prdata;
		if (!is_run && waits != 0) begin
			errors++;
			$display("Transfer to %h took %0d wait states instead of none", addr, waits);
		end
		@(negedge afi_clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic host_cmd(input rw_mgr_pkg::cmd_op_t op, input int low, input logic [31:0] value);
		logic [31:0] unused;
		apb_xfer(1'b1, {op, low[7:0]}, value, unused);
	endtask

	task automatic host_read(input int low, output logic [31:0] rd);
		apb_xfer(1'b0, {4'h0, low[7:0]}, '0, rd);
	endtask

	task automatic put_inst(input int addr, input rw_mgr_pkg::inst_t word);
		inst_mem[addr] = word;
		host_cmd(rw_mgr_pkg::OP_WRITE_INST, addr, 32'(word));
	endtask

	task automatic put_ac(input int addr, input rw_mgr_pkg::ac_word_t word);
		ac_mem[addr] = word;
		host_cmd(rw_mgr_pkg::OP_WRITE_AC, addr, 32'(word));
	endtask

	task automatic load_loop(input int sel, input int target, input int count);
		host_cmd(rw_mgr_pkg::OP_LOAD_JUMP, sel, target);
		host_cmd(rw_mgr_pkg::OP_LOAD_CNTR, sel, count);
		jaddr_model[sel] = target;
		cntr_model[sel]  = count;
	endtask

	task automatic set_cs_mask(input logic [rw_mgr_pkg::NUM_RANKS-1:0] m);
		host_cmd(rw_mgr_pkg::OP_SET_CS_MASK, 0, 32'(m));
		cur_mask = m;
	endtask

	task automatic run_program(input int start);
		build_trace(start);
		budget += trace_q.size() + 4;
		host_cmd(rw_mgr_pkg::OP_RUN, 0, start);
		@(negedge afi_clk);
		if (trace_q.size() != 0) begin
			errors++;
			$display("Program at %0d ended with %0d steps not executed", start, trace_q.size());
			trace_q.delete();
		end
	endtask

	task automatic queue_response(input logic [3:0] code);
		int due;
		logic [rw_mgr_pkg::WDATA_WIDTH-1:0] flip;
		due = cyc + 1 + ($unsigned($random(seed)) % 4);
		if (rsp_due.size() > 0 && due <= rsp_due[$]) begin
			due = rsp_due[$] + 1;
		end
		flip = '0;
		if (flip_on) begin
			flip[$unsigned($random(seed)) % rw_mgr_pkg::WDATA_WIDTH] = 1'b1;
		end
		exp_err |= err_ref(flip);
		rsp_due.push_back(due);
		rsp_data.push_back(wdata_ref(code) ^ flip);
	endtask

	task automatic drain_reads();
		budget += 24;
		while (rsp_due.size() != 0) begin
			@(negedge afi_clk);
		end
		repeat (2) @(negedge afi_clk);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests++;
		$display("test %0d %s: %s", tests, name, (errors == errors_before) ? "ok" : "FAILED");
	endtask

	// read data returns in order, at most one beat group per cycle
	always @(negedge afi_clk) begin
		if (rsp_due.size() > 0 && rsp_due[0] <= cyc) begin
			afi_rdata_valid = 1'b1;
			afi_rdata       = rsp_data.pop_front();
			rsp_due.delete(0);
		end else begin
			afi_rdata_valid = 1'b0;
			afi_rdata       = '0;
		end
	end

	// outputs of the instruction executed in cycle A+1 show up in cycle A+2
	initial begin : output_compare
		int p;
		rw_mgr_pkg::inst_t inst;
		rw_mgr_pkg::ac_word_t ac;
		logic [3:0] dcode;
		logic [2:0] mcode;
		forever begin
			@(posedge afi_clk);
			if (run_go) begin
				run_go = 1'b0;
				@(negedge afi_clk);
				while (trace_q.size() > 0) begin
					@(negedge afi_clk);
					if (trace_q.size() > 0) begin
						p     = trace_q.pop_front();
						inst  = inst_mem[p];
						ac    = ac_mem[inst[rw_mgr_pkg::INST_AC_LSB +: rw_mgr_pkg::AC_ADDR_WIDTH]];
						dcode = inst[rw_mgr_pkg::INST_DO_LSB +: rw_mgr_pkg::DO_CODE_WIDTH];
						mcode = inst[rw_mgr_pkg::INST_DM_LSB +: rw_mgr_pkg::DM_CODE_WIDTH];
						ac_cmp(ac_bus, ac[rw_mgr_pkg::AC_BUS_WIDTH-1:0]);
						cs_cmp(ac_cs_n, cs_ref(ac, cur_mask));
						wdata_cmp(afi_wdata, wdata_ref(dcode));
						dm_cmp(afi_dm, dm_ref(mcode));
						if (inst[rw_mgr_pkg::INST_R_WN_BIT]) begin
							queue_response(dcode);
						end
					end
				end
			end
		end
	end

	initial begin : watchdog
		wait (cyc > budget);
		$display("Timeout: the run made no progress for too long, stopped at cycle %0d", cyc);
		$display("Regression failed");
		$finish;
	end

	initial begin : main
		logic [31:0] rd;
		int e;
		afi_reset_n     = 1'b0;
		psel            = 1'b0;
		penable         = 1'b0;
		pwrite          = 1'b0;
		paddr           = '0;
		pwdata          = '0;
		afi_rdata       = '0;
		afi_rdata_valid = 1'b0;
		run_go          = 1'b0;
		flip_on         = 1'b0;
		cur_mask        = '0;
		exp_err         = '0;
		for (int i = 0; i < rw_mgr_pkg::NUM_LOOPS; i++) begin
			cntr_model[i]  = 0;
			jaddr_model[i] = 0;
		end
		repeat (5) @(negedge afi_clk);
		afi_reset_n = 1'b1;

		e = errors;
		checks++;
		if (pready !== 1'b0) begin
			errors++;
			$display("pready_o is not low after reset");
		end
		host_read(0, rd);
		reg_cmp("error word", rd, '0);
		host_read(1, rd);
		reg_cmp("program counter", rd, '0);
		finish_test("reset state", e);

		e = errors;
		for (int a = 0; a < 16; a++) begin
			put_ac(a, rw_mgr_pkg::ac_word_t'($random(seed)));
		end
		for (int a = 0; a < 3; a++) begin
			put_inst(a, make_inst(1'b0, 1'b0, 1'b0, 0, a, 0, 0));
		end
		put_inst(3, make_inst(1'b1, 1'b0, 1'b0, 0, 3, 0, 0));
		run_program(0);
		host_read(1, rd);
		reg_cmp("program counter", rd, 32'd3);
		finish_test("straight line program", e);

		e = errors;
		put_inst(16, make_inst(1'b0, 1'b0, 1'b0, 0, 4, 0, 0));
		put_inst(17, make_inst(1'b0, 1'b0, 1'b1, 1, 5, 0, 0));
		put_inst(18, make_inst(1'b0, 1'b0, 1'b0, 0, 6, 0, 0));
		put_inst(19, make_inst(1'b1, 1'b0, 1'b0, 0, 7, 0, 0));
		load_loop(1, 16, 3);
		run_program(16);
		host_read(1, rd);
		reg_cmp("program counter", rd, 32'd19);
		finish_test("loop counter", e);

		e = errors;
		set_cs_mask(2'b01);
		run_program(0);
		set_cs_mask(2'b10);
		run_program(0);
		finish_test("chip select mask", e);

		e = errors;
		put_inst(32, make_inst(1'b0, 1'b0, 1'b0, 0, 8, 4'b1010, 2));
		put_inst(33, make_inst(1'b0, 1'b0, 1'b0, 0, 9, 4'b0101, 4));
		put_inst(34, make_inst(1'b0, 1'b0, 1'b0, 0, 10, 4'b1111, 0));
		put_inst(35, make_inst(1'b1, 1'b0, 1'b0, 0, 11, 4'b0011, 1));
		run_program(32);
		finish_test("write pattern", e);

		e = errors;
		put_inst(48, make_inst(1'b0, 1'b1, 1'b0, 0, 12, 4'b1001, 0));
		put_inst(49, make_inst(1'b0, 1'b1, 1'b0, 0, 13, 4'b0110, 3));
		put_inst(50, make_inst(1'b0, 1'b1, 1'b0, 0, 14, 4'b1111, 0));
		put_inst(51, make_inst(1'b1, 1'b0, 1'b0, 0, 15, 4'b0000, 0));
		run_program(48);
		drain_reads();
		host_read(0, rd);
		reg_cmp("error word", rd, 32'(exp_err));
		flip_on = 1'b1;
		run_program(48);
		drain_reads();
		host_read(0, rd);
		reg_cmp("error word", rd, 32'(exp_err));
		host_cmd(rw_mgr_pkg::OP_CLEAR_ERR, 0, 0);
		exp_err = '0;
		host_read(0, rd);
		reg_cmp("error word", rd, '0);
		finish_test("read compare", e);

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: rw_mgr_core.f
rw_mgr_pkg.sv
rw_mgr_ram.sv
rw_mgr_jump_logic.sv
rw_mgr_sequencer.sv
rw_mgr_write_pattern.sv
rw_mgr_read_checker.sv
rw_mgr_apb_ctrl.sv
rw_mgr_core.sv
tb_rw_mgr_core.sv
